// ==== include/sm3_expnd_ref.svh ====
`ifndef SM3_EXPND_REF_SVH
`define SM3_EXPND_REF_SVH

// W_0..W_67 and W'_0..W'_63 of one block, straight from the SM3 recurrence
function automatic void sm3_expnd_ref(
    input  sm3_word_pkg::sm3_word_t blk [sm3_word_pkg::BLOCK_WORDS],
    output sm3_word_pkg::sm3_word_t w   [sm3_word_pkg::EXPND_PAIRS + 4],
    output sm3_word_pkg::sm3_word_t wp  [sm3_word_pkg::EXPND_PAIRS]
);
    sm3_word_pkg::sm3_word_t t;

    // message words first
    for (int j = 0; j < sm3_word_pkg::BLOCK_WORDS; j++) begin
        w[j] = blk[j];
    end

    for (int j = sm3_word_pkg::BLOCK_WORDS; j < sm3_word_pkg::EXPND_PAIRS + 4; j++) begin
        t    = w[j - 16] ^ w[j - 9] ^ {w[j - 3][16:0], w[j - 3][31:17]};
        w[j] = sm3_word_pkg::sm3_p1(t)
             ^ {w[j - 13][24:0], w[j - 13][31:25]}
             ^ w[j - 6];
    end

    // W'_j needs W_(j+4), hence the four extra words
    for (int j = 0; j < sm3_word_pkg::EXPND_PAIRS; j++) begin
        wp[j] = w[j] ^ w[j + 4];
    end
endfunction

`endif

// ==== bench/sm3_expnd_tb.sv ====
`timescale 1ns/10ps

module sm3_expnd_tb;
    import sm3_word_pkg::*;

    `include "sm3_expnd_ref.svh"

    localparam int HALF_PERIOD = 50;                       // 100 ns clock
    localparam int NUM_BLOCKS  = 12;
    localparam int WDOG_CYCLES = NUM_BLOCKS * 100 + 1000;

    logic        clk;
    logic        rst_n;
    pad_beat_t   pad_beat;
    logic        pad_vld;
    logic        pad_rdy;
    expnd_beat_t expnd_beat;
    logic        expnd_vld;

    expnd_beat_t exp_q [$];   // pairs the DUT still owes
    expnd_beat_t exp_beat;
    int          err_cnt    = 0;
    int          seed;
    bit          first_xfer = 1'b0;
    int          blk_words  = 0;  // words taken of the current block
    int          pair_cnt   = 0;  // pairs seen of the current block
    int          lo_run     = 0;  // consecutive cycles of ready low
    int          pair_total = 0;

    sm3_expnd_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pad_i       (pad_beat),
        .pad_vld_i   (pad_vld),
        .pad_rdy_o   (pad_rdy),
        .expnd_o     (expnd_beat),
        .expnd_vld_o (expnd_vld)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    ////////////////////
    // expected pairs

    task automatic queue_expected(input sm3_word_t blk [BLOCK_WORDS], input logic lst);
        sm3_word_t   w  [EXPND_PAIRS + 4];
        sm3_word_t   wp [EXPND_PAIRS];
        expnd_beat_t beat;
        sm3_expnd_ref(blk, w, wp);
        for (int j = 0; j < EXPND_PAIRS; j++) begin
            beat.wj  = w[j];
            beat.wjj = wp[j];
            beat.lst = lst && (j == EXPND_PAIRS - 1);  // only the final pair
            exp_q.push_back(beat);
        end
    endtask

    // W16 of the padded "abc" block as printed in the SM3 standard example
    task automatic check_abc_reference(input sm3_word_t blk [BLOCK_WORDS]);
        sm3_word_t w  [EXPND_PAIRS + 4];
        sm3_word_t wp [EXPND_PAIRS];
        sm3_expnd_ref(blk, w, wp);
        assert (w[16] == 32'h9092e200) else begin
            err_cnt++;
            $display("Mismatch at %0t: reference W16 %h for abc, standard gives 9092e200",
                     $time, w[16]);
        end
    endtask

    ////////////////////
    // stimulus

    // entered and left just after a rising edge
    task automatic send_word(input pad_beat_t beat, input int gap);
        for (int n = 0; n < gap; n++) begin
            pad_vld       <= 1'b0;
            pad_beat.data <= $random(seed);  // junk while idle
            pad_beat.lst  <= 1'b0;
            @(posedge clk);
        end
        pad_vld  <= 1'b1;
        pad_beat <= beat;
        do begin
            @(negedge clk);
        end while (!pad_rdy);  // held through back-pressure
        @(posedge clk);
    endtask

    task automatic send_block(input sm3_word_t blk [BLOCK_WORDS], input logic lst,
                              input int gap_max);
        int        gap;
        pad_beat_t beat;
        queue_expected(blk, lst);
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            gap = (gap_max > 0) ? int'($unsigned($random(seed)) % (gap_max + 1)) : 0;
            beat.data = blk[i];
            beat.lst  = lst;
            send_word(beat, gap);
        end
    endtask

    initial begin
        sm3_word_t blk [BLOCK_WORDS];
        logic      lst;
        int        gap_max;
        seed     = 32'h5583;
        rst_n    = 1'b0;
        pad_vld  = 1'b0;
        pad_beat = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // padded "abc" as the last block of its message
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            blk[i] = '0;
        end
        blk[0]  = 32'h61626380;
        blk[15] = 32'h00000018;
        check_abc_reference(blk);
        send_block(blk, 1'b1, 2);

        // random blocks where every third has no gaps
        for (int b = 1; b < NUM_BLOCKS; b++) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                blk[i] = $random(seed);
            end
            lst     = (b % 4 == 3) || (b == NUM_BLOCKS - 1);
            gap_max = (b % 3 == 1) ? 0 : 3;
            send_block(blk, lst, gap_max);
        end
        pad_vld <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);  // catch stray pairs
        assert (pair_total == NUM_BLOCKS * EXPND_PAIRS) else begin
            err_cnt++;
            $display("Mismatch at %0t: %0d pairs seen, %0d expected",
                     $time, pair_total, NUM_BLOCKS * EXPND_PAIRS);
        end
        $display("checked %0d pairs, %0d errors", pair_total, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    ////////////////////
    // comparison at mid-cycle

    always @(negedge clk) begin
        if (rst_n) begin
            if (!first_xfer) begin
                assert (pad_rdy && !expnd_vld) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: after reset ready %b valid %b",
                             $time, pad_rdy, expnd_vld);
                end
            end

            // ready low only for the expansion run after word 15
            if (!pad_rdy) begin
                assert (blk_words == BLOCK_WORDS && expnd_vld) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: ready low with %0d words taken, valid %b",
                             $time, blk_words, expnd_vld);
                end
                lo_run++;
            end else if (lo_run != 0) begin
                assert (lo_run == EXPND_CYCLES) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: ready was low for %0d cycles", $time, lo_run);
                end
                lo_run    = 0;
                blk_words = 0;
            end else begin
                assert (blk_words < BLOCK_WORDS) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: ready high right after word 15", $time);
                end
            end

            if (expnd_vld) begin
                if (pad_rdy) begin  // pairs 0..10 ride on words 5..15
                    assert (pad_vld && blk_words == pair_cnt + PRELOAD_WORDS) else begin
                        err_cnt++;
                        $display("Mismatch at %0t: pair %0d left with %0d words taken",
                                 $time, pair_cnt, blk_words);
                    end
                end
                assert (exp_q.size() != 0) else begin
                    err_cnt++;
                    $display("Unexpected output pair at %0t, no pair was expected", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_beat = exp_q.pop_front();
                    assert (expnd_beat == exp_beat) else begin
                        err_cnt++;
                        $display("Mismatch at %0t: pair %0d got %h %h %b, expected %h %h %b",
                                 $time, pair_cnt, expnd_beat.wj, expnd_beat.wjj,
                                 expnd_beat.lst, exp_beat.wj, exp_beat.wjj, exp_beat.lst);
                    end
                end
                pair_cnt = (pair_cnt + 1) % EXPND_PAIRS;
                pair_total++;
            end

            if (pad_vld && pad_rdy) begin  // taken on the coming edge
                blk_words++;
                first_xfer = 1'b1;
            end
        end
    end

    ////////////////////
    // watchdog

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles, %0d errors so far",
                 WDOG_CYCLES, err_cnt);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the SM3 expansion testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module sm3_expnd_tb \
    -f sm3_expnd.f -o sm3_expnd_sim > build.log 2>&1 \
    && ./obj_dir/sm3_expnd_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// ==== sm3_expnd.f ====
+incdir+include
src/sm3_word_pkg.sv
src/sm3_ctrl_pkg.sv
src/sm3_expnd_ctrl.sv
src/sm3_word_window.sv
src/sm3_expnd_top.sv
bench/sm3_expnd_tb.sv

// ==== src/sm3_ctrl_pkg.sv ====
package sm3_ctrl_pkg;

    ////////////////////
    // controller phases

    // IDLE      waiting for word 0
    // LOAD      words 0..4 go in, nothing comes out
    // LOAD_OUT  words 5..15 go in, pairs 0..10 come out
    // EXPND     input held off, pairs 11..63 from the recurrence
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOAD     = 2'd1,
        LOAD_OUT = 2'd2,
        EXPND    = 2'd3
    } expnd_phase_t;

    ////////////////////
    // counter widths

    localparam int WORD_CNT_W = 4;  // 0..15, wraps after the last word
    localparam int EXP_CNT_W  = 6;  // 0..52

    ////////////////////
    // window control

    typedef struct packed {
        logic shift;       // advance the window by one word
        logic take_input;  // push the input word, else the expanded word
    } win_ctrl_t;

endpackage

// ==== src/sm3_expnd_ctrl.sv ====
`timescale 1ns/10ps

module sm3_expnd_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pad_vld_i,
    input  logic                    pad_lst_i,
    output logic                    pad_rdy_o,
    output sm3_ctrl_pkg::win_ctrl_t win_ctrl_o,
    output logic                    expnd_vld_o,
    output logic                    expnd_lst_o
);
    import sm3_word_pkg::*;
    import sm3_ctrl_pkg::*;

    // counter values that end a phase
    localparam logic [WORD_CNT_W-1:0] LOAD_LAST_IDX = WORD_CNT_W'(PRELOAD_WORDS - 1);
    localparam logic [WORD_CNT_W-1:0] BLK_LAST_IDX  = WORD_CNT_W'(BLOCK_WORDS - 1);
    localparam logic [EXP_CNT_W-1:0]  EXP_LAST_IDX  = EXP_CNT_W'(EXPND_CYCLES - 1);

    expnd_phase_t          phase_q;
    expnd_phase_t          phase_d;
    logic [WORD_CNT_W-1:0] word_cnt_q;   // words taken of this block
    logic [EXP_CNT_W-1:0]  exp_cnt_q;    // expansion cycles done
    logic                  lst_flg_q;    // block carries the message end
    logic                  xfer;
    logic                  in_expnd;
    logic                  exp_done;

    ////////////////////
    // handshake

    assign in_expnd  = (phase_q == EXPND);
    assign pad_rdy_o = !in_expnd;              // phase only, never valid
    assign xfer      = pad_vld_i && pad_rdy_o;
    assign exp_done  = in_expnd && (exp_cnt_q == EXP_LAST_IDX);

    ////////////////////
    // phase FSM

    always_comb begin
        phase_d = phase_q;
        unique case (phase_q)
            IDLE: begin
                if (xfer) phase_d = LOAD;
            end
            LOAD: begin
                if (xfer && word_cnt_q == LOAD_LAST_IDX) phase_d = LOAD_OUT;
            end
            LOAD_OUT: begin
                if (xfer && word_cnt_q == BLK_LAST_IDX) phase_d = EXPND;
            end
            EXPND: begin
                if (exp_done) phase_d = IDLE;
            end
            default: phase_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    ////////////////////
    // counters

    // wraps to zero on word 15, ready for the next block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt_q <= '0;
        end else if (xfer) begin
            word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_cnt_q <= '0;
        end else if (exp_done) begin
            exp_cnt_q <= '0;
        end else if (in_expnd) begin
            exp_cnt_q <= exp_cnt_q + 1'b1;
        end
    end

    // last-block flag, held until pair 63 leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lst_flg_q <= 1'b0;
        end else if (xfer && pad_lst_i) begin
            lst_flg_q <= 1'b1;
        end else if (expnd_lst_o) begin
            lst_flg_q <= 1'b0;
        end
    end

    ////////////////////
    // window control and output strobes

    assign win_ctrl_o = '{shift: xfer || in_expnd, take_input: !in_expnd};

    // pairs 0..10 ride on the input transfers, 11..63 on every expansion cycle
    assign expnd_vld_o = (phase_q == LOAD_OUT && xfer) || in_expnd;
    assign expnd_lst_o = lst_flg_q && exp_done;

endmodule

// ==== src/sm3_expnd_top.sv ====
`timescale 1ns/10ps

module sm3_expnd_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  sm3_word_pkg::pad_beat_t   pad_i,
    input  logic                      pad_vld_i,
    output logic                      pad_rdy_o,
    output sm3_word_pkg::expnd_beat_t expnd_o,
    output logic                      expnd_vld_o
);
    import sm3_word_pkg::*;
    import sm3_ctrl_pkg::*;

    win_ctrl_t win_ctrl;
    sm3_word_t wj;
    sm3_word_t wjj;
    logic      expnd_lst;

    sm3_expnd_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .pad_vld_i   (pad_vld_i),
        .pad_lst_i   (pad_i.lst),
        .pad_rdy_o   (pad_rdy_o),
        .win_ctrl_o  (win_ctrl),
        .expnd_vld_o (expnd_vld_o),
        .expnd_lst_o (expnd_lst)
    );

    sm3_word_window u_window (
        .clk        (clk),
        .rst_n      (rst_n),
        .pad_word_i (pad_i.data),
        .win_ctrl_i (win_ctrl),
        .wj_o       (wj),
        .wjj_o      (wjj)
    );

    // no register here, pairs leave in the cycle they are tapped
    assign expnd_o = '{wj: wj, wjj: wjj, lst: expnd_lst};

endmodule

// ==== src/sm3_word_pkg.sv ====
package sm3_word_pkg;

    ////////////////////
    // word and block constants

    typedef logic [31:0] sm3_word_t;

    localparam int BLOCK_WORDS   = 16;  // words in one padded block
    localparam int EXPND_PAIRS   = 64;  // W/W' pairs per block
    localparam int PRELOAD_WORDS = 5;   // first pair needs W0 and W4
    localparam int EXPND_CYCLES  = 53;  // pairs 11..63, input held off

    ////////////////////
    // permutation

    // P1(x) = x ^ (x <<< 15) ^ (x <<< 23)
    function automatic sm3_word_t sm3_p1(input sm3_word_t x);
        return x ^ {x[16:0], x[31:17]} ^ {x[8:0], x[31:9]};
    endfunction

    ////////////////////
    // beats

    // one input word of a padded block
    typedef struct packed {
        sm3_word_t data;
        logic      lst;   // word belongs to the last block of the message
    } pad_beat_t;

    // one expansion pair
    typedef struct packed {
        sm3_word_t wj;    // W_j
        sm3_word_t wjj;   // W'_j = W_j ^ W_(j+4)
        logic      lst;   // final pair of the message
    } expnd_beat_t;

endpackage

// ==== src/sm3_word_window.sv ====
`timescale 1ns/10ps

module sm3_word_window (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sm3_word_pkg::sm3_word_t pad_word_i,
    input  sm3_ctrl_pkg::win_ctrl_t win_ctrl_i,
    output sm3_word_pkg::sm3_word_t wj_o,
    output sm3_word_pkg::sm3_word_t wjj_o
);
    import sm3_word_pkg::*;

    localparam int NEW_POS = BLOCK_WORDS - 1;              // youngest word
    localparam int WJ_POS  = BLOCK_WORDS - PRELOAD_WORDS;  // four behind the youngest

    sm3_word_t win_q [BLOCK_WORDS];  // [0] is W_(j-16) while expanding
    sm3_word_t p1_in;
    sm3_word_t w_new;
    sm3_word_t push_word;

    ////////////////////
    // recurrence

    // W_j = P1(W_j-16 ^ W_j-9 ^ (W_j-3 <<< 15)) ^ (W_j-13 <<< 7) ^ W_j-6
    assign p1_in = win_q[0] ^ win_q[7] ^ {win_q[13][16:0], win_q[13][31:17]};
    assign w_new = sm3_p1(p1_in)
                 ^ {win_q[3][24:0], win_q[3][31:25]}
                 ^ win_q[10];

    assign push_word = win_ctrl_i.take_input ? pad_word_i : w_new;

    ////////////////////
    // shift window

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                win_q[i] <= '0;
            end
        end else if (win_ctrl_i.shift) begin
            for (int i = 0; i < NEW_POS; i++) begin
                win_q[i] <= win_q[i + 1];  // drop the oldest
            end
            win_q[NEW_POS] <= push_word;
        end
    end

    ////////////////////
    // output taps

    assign wj_o  = win_q[WJ_POS];
    assign wjj_o = win_q[WJ_POS] ^ win_q[NEW_POS];  // W_j ^ W_(j+4)

endmodule
